// File: src/zest_bus_pkg.sv
`default_nettype none

package zest_bus_pkg;

    // --------------------
    // Address map
    // --------------------

    // Region select field of the byte address
    localparam int ADR_REGION_HI = 23;
    localparam int ADR_REGION_LO = 16;

    // Word index field, byte lanes dropped
    localparam int ADR_WORD_HI = 10;
    localparam int ADR_WORD_LO = 2;

    // Region bases
    localparam logic [7:0] BASE_SFR = 8'h20;
    localparam logic [7:0] BASE_AWG = 8'h23;

    // --------------------
    // Wishbone classic
    // --------------------

    // Master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: src/zest_dac_pkg.sv
`default_nettype none

package zest_dac_pkg;

    // Sample widths
    localparam int DAC_DW = 14;
    localparam int DUC_DW = 16;

    // Waveform memory geometry
    localparam int AWG_DEPTH = 256;
    localparam int AWG_AW    = 8;

    typedef logic [DAC_DW-1:0]        dac_sample_t;
    typedef logic signed [DUC_DW-1:0] duc_sample_t;

    // --------------------
    // Control registers
    // --------------------

    // Register 0, board pins in the top byte
    typedef struct packed {
        logic [2:0]  rsvd_hi;
        logic        pwr_en_b;
        logic        pwr_sync;
        logic        adc_sync;
        logic        dac_reset;
        logic        adc_pdwn;
        logic [23:0] rsvd_lo;
    } ctrl0_t;

    // Register 1, DAC source selection
    typedef struct packed {
        logic [27:0] rsvd;
        logic        dac1_enable;
        logic        dac1_src_sel;
        logic        dac0_enable;
        logic        dac0_src_sel;
    } ctrl1_t;

    // Same storage word, read per register layout
    typedef union packed {
        logic [31:0] raw;
        ctrl0_t      c0;
        ctrl1_t      c1;
    } sfr_word_u;

    // Board pins, pwr_en already active high
    typedef struct packed {
        logic adc_pdwn;
        logic dac_reset;
        logic adc_sync;
        logic pwr_sync;
        logic pwr_en;
    } board_ctrl_t;

    // Per channel enable and source
    typedef struct packed {
        logic dac1_enable;
        logic dac1_src_sel;
        logic dac0_enable;
        logic dac0_src_sel;
    } dac_sel_t;

    // I on channel 0, Q on channel 1
    typedef struct packed {
        dac_sample_t i;
        dac_sample_t q;
    } dac_pair_t;

endpackage

`default_nettype wire

// File: src/zest_wb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module zest_wb_decode
    import zest_bus_pkg::*;
(
    input  logic    dac_clk_out,
    input  logic    rst_n_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,
    output wb_req_t sfr_req_o,
    input  wb_rsp_t sfr_rsp_i,
    output wb_req_t awg_req_o,
    input  wb_rsp_t awg_rsp_i
);

    logic [7:0] region;
    logic       sel_sfr;
    logic       sel_awg;
    logic       req_act;
    logic       miss_ack_q;

    // Region compare on address bits 23:16
    assign region  = wb_req_i.adr[ADR_REGION_HI:ADR_REGION_LO];
    assign sel_sfr = (region == BASE_SFR);
    assign sel_awg = (region == BASE_AWG);
    assign req_act = wb_req_i.cyc && wb_req_i.stb;

    // Strobe only reaches the addressed slave
    always_comb begin
        sfr_req_o     = wb_req_i;
        sfr_req_o.stb = wb_req_i.stb && sel_sfr;
        awg_req_o     = wb_req_i;
        awg_req_o.stb = wb_req_i.stb && sel_awg;
    end

    // --------------------
    // Unmapped regions
    // --------------------

    // Single cycle ack, writes dropped
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            miss_ack_q <= 1'b0;
        end else begin
            miss_ack_q <= req_act && !sel_sfr && !sel_awg && !miss_ack_q;
        end
    end

    // Response back from whichever slave is addressed
    always_comb begin
        if (sel_sfr) begin
            wb_rsp_o = sfr_rsp_i;
        end else if (sel_awg) begin
            wb_rsp_o = awg_rsp_i;
        end else begin
            wb_rsp_o.ack = miss_ack_q;
            wb_rsp_o.dat = '0;
        end
    end

    // Any ack must answer a request held in the cycle before
    a_ack_in_cycle: assert property (
        @(posedge dac_clk_out) disable iff (!rst_n_i)
        $rose(wb_rsp_o.ack) |-> $past(wb_req_i.cyc && wb_req_i.stb)
    );

endmodule

`default_nettype wire

// File: src/zest_sfr.sv
`timescale 1ns/1ps
`default_nettype none

module zest_sfr
    import zest_bus_pkg::*;
    import zest_dac_pkg::*;
(
    input  logic        dac_clk_out,
    input  logic        rst_n_i,
    input  wb_req_t     wb_req_i,
    output wb_rsp_t     wb_rsp_o,
    output board_ctrl_t board_o,
    output dac_sel_t    dac_sel_o
);

    logic [ADR_WORD_HI-ADR_WORD_LO:0] word;
    logic                             req_act;
    logic                             wr_en;
    logic [31:0]                      rd_data;
    sfr_word_u                        ctrl0_q;
    sfr_word_u                        ctrl1_q;
    wb_rsp_t                          rsp_q;

    assign word = wb_req_i.adr[ADR_WORD_HI:ADR_WORD_LO];

    // New access only, not the cycle holding ack
    assign req_act = wb_req_i.cyc && wb_req_i.stb && !rsp_q.ack;
    assign wr_en   = req_act && wb_req_i.we;

    // --------------------
    // Register file
    // --------------------

    // Update lands on the same edge that raises ack
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            ctrl0_q.raw <= '0;
            ctrl1_q.raw <= '0;
        end else if (wr_en) begin
            case (word)
                'd0:     ctrl0_q.raw <= wb_req_i.dat;
                'd1:     ctrl1_q.raw <= wb_req_i.dat;
                default: ;
            endcase
        end
    end

    // Words 2 and up read as zero
    always_comb begin
        case (word)
            'd0:     rd_data = ctrl0_q.raw;
            'd1:     rd_data = ctrl1_q.raw;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q.ack <= req_act;
            if (req_act) begin
                rsp_q.dat <= rd_data;
            end
        end
    end

    assign wb_rsp_o = rsp_q;

    // --------------------
    // Field decode
    // --------------------

    // Board pins from register 0 view
    always_comb begin
        board_o.adc_pdwn  = ctrl0_q.c0.adc_pdwn;
        board_o.dac_reset = ctrl0_q.c0.dac_reset;
        board_o.adc_sync  = ctrl0_q.c0.adc_sync;
        board_o.pwr_sync  = ctrl0_q.c0.pwr_sync;
        // Supply enable pin is active low in the register
        board_o.pwr_en    = !ctrl0_q.c0.pwr_en_b;
    end

    // Source selection from register 1 view
    always_comb begin
        dac_sel_o.dac0_src_sel = ctrl1_q.c1.dac0_src_sel;
        dac_sel_o.dac0_enable  = ctrl1_q.c1.dac0_enable;
        dac_sel_o.dac1_src_sel = ctrl1_q.c1.dac1_src_sel;
        dac_sel_o.dac1_enable  = ctrl1_q.c1.dac1_enable;
    end

endmodule

`default_nettype wire

// File: src/zest_awg.sv
`timescale 1ns/1ps
`default_nettype none

module zest_awg
    import zest_bus_pkg::*;
    import zest_dac_pkg::*;
(
    input  logic        dac_clk_out,
    input  logic        rst_n_i,
    input  wb_req_t     wb_req_i,
    output wb_rsp_t     wb_rsp_o,
    output dac_sample_t sample_o,
    output logic        valid_o
);

    logic [ADR_WORD_HI-ADR_WORD_LO:0] word;
    logic [AWG_AW-1:0]                mem_idx;
    logic                             is_sample;
    logic                             req_act;
    logic                             wr_en;
    logic [31:0]                      rd_data;
    wb_rsp_t                          rsp_q;

    // Playback state
    logic                             run_q;
    logic [AWG_AW:0]                  len_q;
    logic [AWG_AW-1:0]                ptr_q;
    logic                             active;
    logic                             wrap;
    dac_sample_t                      sample_q;
    logic                             valid_q;

    dac_sample_t                      mem [AWG_DEPTH];

    // Word 0 control, words 256..511 sample memory
    assign word      = wb_req_i.adr[ADR_WORD_HI:ADR_WORD_LO];
    assign is_sample = word[AWG_AW];
    assign mem_idx   = word[AWG_AW-1:0];

    assign req_act = wb_req_i.cyc && wb_req_i.stb && !rsp_q.ack;
    assign wr_en   = req_act && wb_req_i.we;

    // --------------------
    // Bus side
    // --------------------

    // Run bit 31, length bits 8:0
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
            len_q <= '0;
        end else if (wr_en && word == '0) begin
            run_q <= wb_req_i.dat[31];
            len_q <= wb_req_i.dat[AWG_AW:0];
        end
    end

    // Write port, low 14 bits kept
    always_ff @(posedge dac_clk_out) begin
        if (wr_en && is_sample) begin
            mem[mem_idx] <= wb_req_i.dat[DAC_DW-1:0];
        end
    end

    always_comb begin
        if (is_sample) begin
            rd_data = {{(32-DAC_DW){1'b0}}, mem[mem_idx]};
        end else if (word == '0) begin
            rd_data = {run_q, {(31-AWG_AW-1){1'b0}}, len_q};
        end else begin
            rd_data = '0;
        end
    end

    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q.ack <= req_act;
            if (req_act) begin
                rsp_q.dat <= rd_data;
            end
        end
    end

    assign wb_rsp_o = rsp_q;

    // --------------------
    // Playback
    // --------------------

    assign active = run_q && (len_q != '0);
    // Greater-or-equal also catches a length cut while running
    assign wrap   = ({1'b0, ptr_q} >= len_q - 1'b1);

    // Pointer loops 0..length-1, parked at 0 when stopped
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            ptr_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= active;
            if (!active || wrap) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    // Second read port, one cycle latency
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            sample_q <= '0;
        end else begin
            sample_q <= mem[ptr_q];
        end
    end

    assign sample_o = sample_q;
    assign valid_o  = valid_q;

    // Pointer in range once length has settled
    a_ptr_in_range: assert property (
        @(posedge dac_clk_out) disable iff (!rst_n_i)
        (active && $stable(len_q)) |-> ({1'b0, ptr_q} < len_q)
    );

endmodule

`default_nettype wire

// File: src/zest_dac_mux.sv
`timescale 1ns/1ps
`default_nettype none

module zest_dac_mux
    import zest_dac_pkg::*;
(
    input  logic        dac_clk_out,
    input  logic        rst_n_i,
    input  dac_sel_t    dac_sel_i,
    input  dac_sample_t awg_sample_i,
    input  logic        awg_valid_i,
    input  duc_sample_t duc_i_i,
    input  duc_sample_t duc_q_i,
    output dac_pair_t   dac_o
);

    dac_sample_t awg_q;
    dac_pair_t   pair_d;
    dac_pair_t   pair_q;

    // Zero, DUC top bits or generator sample
    function automatic dac_sample_t pick(
        input logic        enable,
        input logic        src_sel,
        input duc_sample_t duc,
        input dac_sample_t awg
    );
        dac_sample_t res;
        if (!enable) begin
            res = '0;
        end else if (src_sel) begin
            res = awg;
        end else begin
            res = duc[DUC_DW-1 -: DAC_DW];
        end
        return res;
    endfunction

    // Generator retimed, blanked while not valid
    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            awg_q <= '0;
        end else begin
            awg_q <= awg_valid_i ? awg_sample_i : '0;
        end
    end

    always_comb begin
        pair_d.i = pick(dac_sel_i.dac0_enable, dac_sel_i.dac0_src_sel, duc_i_i, awg_q);
        pair_d.q = pick(dac_sel_i.dac1_enable, dac_sel_i.dac1_src_sel, duc_q_i, awg_q);
    end

    // --------------------
    // Output register
    // --------------------

    always_ff @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            pair_q <= '0;
        end else begin
            pair_q <= pair_d;
        end
    end

    assign dac_o = pair_q;

    // Disabled channel is quiet on the next sample
    a_i_disabled: assert property (
        @(posedge dac_clk_out) disable iff (!rst_n_i)
        !dac_sel_i.dac0_enable |=> (dac_o.i == '0)
    );

    a_q_disabled: assert property (
        @(posedge dac_clk_out) disable iff (!rst_n_i)
        !dac_sel_i.dac1_enable |=> (dac_o.q == '0)
    );

endmodule

`default_nettype wire

// File: src/zest_dac.sv
`timescale 1ns/1ps
`default_nettype none

module zest_dac
    import zest_bus_pkg::*;
    import zest_dac_pkg::*;
(
    input  logic        dac_clk_out,
    input  logic        rst_n_i,
    input  wb_req_t     wb_req_i,
    output wb_rsp_t     wb_rsp_o,
    input  duc_sample_t duc_i_i,
    input  duc_sample_t duc_q_i,
    output board_ctrl_t board_o,
    output dac_pair_t   dac_o
);

    // Bus fabric
    wb_req_t     sfr_req;
    wb_rsp_t     sfr_rsp;
    wb_req_t     awg_req;
    wb_rsp_t     awg_rsp;

    // Data path
    dac_sel_t    dac_sel;
    dac_sample_t awg_sample;
    logic        awg_valid;

    zest_wb_decode zest_wb_decode_i (
        .dac_clk_out (dac_clk_out),
        .rst_n_i     (rst_n_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .sfr_req_o   (sfr_req),
        .sfr_rsp_i   (sfr_rsp),
        .awg_req_o   (awg_req),
        .awg_rsp_i   (awg_rsp)
    );

    zest_sfr zest_sfr_i (
        .dac_clk_out (dac_clk_out),
        .rst_n_i     (rst_n_i),
        .wb_req_i    (sfr_req),
        .wb_rsp_o    (sfr_rsp),
        .board_o     (board_o),
        .dac_sel_o   (dac_sel)
    );

    zest_awg zest_awg_i (
        .dac_clk_out (dac_clk_out),
        .rst_n_i     (rst_n_i),
        .wb_req_i    (awg_req),
        .wb_rsp_o    (awg_rsp),
        .sample_o    (awg_sample),
        .valid_o     (awg_valid)
    );

    zest_dac_mux zest_dac_mux_i (
        .dac_clk_out  (dac_clk_out),
        .rst_n_i      (rst_n_i),
        .dac_sel_i    (dac_sel),
        .awg_sample_i (awg_sample),
        .awg_valid_i  (awg_valid),
        .duc_i_i      (duc_i_i),
        .duc_q_i      (duc_q_i),
        .dac_o        (dac_o)
    );

endmodule

`default_nettype wire

// File: test/zest_dac_tests.svh
`ifndef ZEST_DAC_TESTS_SVH
`define ZEST_DAC_TESTS_SVH

// --------------------
// Registers and pins
// --------------------

// Pin order adc_pdwn down to pwr_en, pwr_en low active in bit 28
function automatic logic [4:0] expected_pins(input logic [31:0] word);
    return {word[24], word[25], word[26], word[27], !word[28]};
endfunction

task automatic reg_readback();
    logic [31:0] word;
    logic [31:0] rd;
    int          n;
    check("reset_pins", 32'h1, 32'(board));
    check("reset_dac", 32'h0, 32'(dac));
    for (n = 0; n < 4; n++) begin
        word = next_rand();
        wb_write(word_addr(BASE_SFR, 0), word);
        wb_read(word_addr(BASE_SFR, 0), rd);
        check("ctrl0_readback", word, rd);
        check("board_pins", 32'(expected_pins(word)), 32'(board));
        word = next_rand();
        wb_write(word_addr(BASE_SFR, 1), word);
        wb_read(word_addr(BASE_SFR, 1), rd);
        check("ctrl1_readback", word, rd);
    end
endtask

// Unmapped region acks with zero, register 0 untouched
task automatic unmapped_region();
    logic [31:0] word;
    logic [31:0] rd;
    word = next_rand();
    wb_write(word_addr(BASE_SFR, 0), word);
    // Inverted data so a leaked write would show in register 0
    wb_write(word_addr(8'h05, 0), ~word);
    wb_read(word_addr(8'h05, 0), rd);
    check("unmapped_read", 32'h0, rd);
    wb_read(word_addr(BASE_SFR, 0), rd);
    check("unmapped_no_effect", word, rd);
    wb_read(word_addr(BASE_SFR, 2), rd);
    check("sfr_word2", 32'h0, rd);
endtask

// --------------------
// Upconverter path
// --------------------

task automatic duc_passthrough();
    logic [31:0] r;
    duc_sample_t di;
    duc_sample_t dq;
    int          n;
    // Both channels on, DUC source
    wb_write(word_addr(BASE_SFR, 1), 32'h0000_000a);
    for (n = 0; n < 4; n++) begin
        r     = next_rand();
        di    = r[15:0];
        dq    = r[31:16];
        duc_i = di;
        duc_q = dq;
        idle_cycles(3);
        check("duc_i", 32'(di[15:2]), 32'(dac.i));
        check("duc_q", 32'(dq[15:2]), 32'(dac.q));
    end
    // Channel 0 off
    wb_write(word_addr(BASE_SFR, 1), 32'h0000_0008);
    idle_cycles(2);
    check("i_disabled", 32'h0, 32'(dac.i));
    check("q_still_on", 32'(dq[15:2]), 32'(dac.q));
    // Channel 1 off, channel 0 back
    wb_write(word_addr(BASE_SFR, 1), 32'h0000_0002);
    idle_cycles(2);
    check("q_disabled", 32'h0, 32'(dac.q));
    check("i_back_on", 32'(di[15:2]), 32'(dac.i));
endtask

// --------------------
// Waveform generator
// --------------------

task automatic waveform_playback();
    logic [31:0] r;
    logic [31:0] rd;
    int          n;
    int          idx;
    int          waited;
    awg_len = 4 + int'(next_rand() % 32'd253);
    // Nonzero samples so the first output is easy to spot
    for (n = 0; n < awg_len; n++) begin
        r = next_rand();
        if (r[13:0] == 14'h0) begin
            r[0] = 1'b1;
        end
        awg_mem[n] = r[13:0];
        wb_write(word_addr(BASE_AWG, 256 + n), r);
    end
    for (n = 0; n < awg_len; n++) begin
        wb_read(word_addr(BASE_AWG, 256 + n), rd);
        check("awg_readback", {18'h0, awg_mem[n]}, rd);
    end
    // Channel 0 on generator, channel 1 off
    wb_write(word_addr(BASE_SFR, 1), 32'h0000_0003);
    idle_cycles(2);
    check("awg_idle", 32'h0, 32'(dac.i));
    wb_write(word_addr(BASE_AWG, 0), {1'b1, 22'h0, 9'(awg_len)});
    wb_read(word_addr(BASE_AWG, 0), rd);
    check("awg_ctrl_run", {1'b1, 22'h0, 9'(awg_len)}, rd);
    waited = 0;
    while (dac.i == '0) begin
        if (waited >= 16) begin
            abort_run("Generator sample never reached the I output");
        end else begin
            waited++;
            @(negedge dac_clk_out);
        end
    end
    // Memory order, wrapping after the last sample
    idx = 0;
    for (n = 0; n < 3 * awg_len; n++) begin
        check("awg_playback", 32'(awg_mem[idx]), 32'(dac.i));
        idx = (idx + 1 == awg_len) ? 0 : idx + 1;
        @(negedge dac_clk_out);
    end
endtask

task automatic generator_stop();
    logic [31:0] r;
    logic [31:0] rd;
    duc_sample_t dq;
    int          n;
    int          waited;
    r     = next_rand();
    dq    = r[15:0];
    duc_q = dq;
    // Channel 0 stays on generator, channel 1 on DUC
    wb_write(word_addr(BASE_SFR, 1), 32'h0000_000b);
    idle_cycles(2);
    check("q_on_duc", 32'(dq[15:2]), 32'(dac.q));
    wb_write(word_addr(BASE_AWG, 0), {1'b0, 22'h0, 9'(awg_len)});
    wb_read(word_addr(BASE_AWG, 0), rd);
    check("awg_ctrl_stop", {1'b0, 22'h0, 9'(awg_len)}, rd);
    waited = 0;
    while (dac.i != '0) begin
        if (waited >= 16) begin
            abort_run("I output did not go quiet after the generator stopped");
        end else begin
            waited++;
            @(negedge dac_clk_out);
        end
    end
    for (n = 0; n < 8; n++) begin
        check("awg_stopped_i", 32'h0, 32'(dac.i));
        check("duc_q_kept", 32'(dq[15:2]), 32'(dac.q));
        @(negedge dac_clk_out);
    end
endtask

`endif

// File: test/zest_dac_tb.sv
`timescale 1ns/1ps
`default_nettype none

module zest_dac_tb
    import zest_bus_pkg::*;
    import zest_dac_pkg::*;
    ();

    // --------------------
    // Clock, reset, DUT
    // --------------------

    logic        dac_clk_out = 1'b0;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    duc_sample_t duc_i;
    duc_sample_t duc_q;
    board_ctrl_t board;
    dac_pair_t   dac;

    // LCG state and the waveform shared by the playback tests
    logic [31:0] lcg_state = 32'h5bc8;
    dac_sample_t awg_mem [AWG_DEPTH];
    int          awg_len;

    // 40 ns period
    always #20 dac_clk_out = ~dac_clk_out;

    zest_dac zest_dac_i (
        .dac_clk_out (dac_clk_out),
        .rst_n_i     (rst_n),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp),
        .duc_i_i     (duc_i),
        .duc_q_i     (duc_q),
        .board_o     (board),
        .dac_o       (dac)
    );

    // --------------------
    // Helpers
    // --------------------

    // Numerical Recipes constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Byte address from region and word index
    function automatic logic [31:0] word_addr(input logic [7:0] region, input int unsigned word);
        logic [15:0] offset;
        offset = 16'(word * 4);
        return {8'h00, region, offset};
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h",
                                test, expected, actual));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge dac_clk_out);
    endtask

    // Ack sampled on falling edges, gives up after 16 cycles
    task automatic wait_ack(input logic [31:0] addr);
        int waited;
        waited = 0;
        @(negedge dac_clk_out);
        while (!wb_rsp.ack) begin
            if (waited >= 16) begin
                abort_run($sformatf("No bus ack for address %h", addr));
            end else begin
                waited++;
                @(negedge dac_clk_out);
            end
        end
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge dac_clk_out);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = addr;
        wb_req.dat = data;
        wait_ack(addr);
        // Cycle ends on the edge that shows ack
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge dac_clk_out);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = addr;
        wb_req.dat = '0;
        wait_ack(addr);
        data   = wb_rsp.dat;
        wb_req = '0;
    endtask

    `include "zest_dac_tests.svh"

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        rst_n   = 1'b0;
        wb_req  = '0;
        duc_i   = '0;
        duc_q   = '0;
        awg_len = 0;
        // Three rising edges with reset low
        repeat (3) @(negedge dac_clk_out);
        rst_n = 1'b1;
        @(negedge dac_clk_out);
        reg_readback();
        unmapped_region();
        duc_passthrough();
        waveform_playback();
        generator_stop();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+test
src/zest_bus_pkg.sv
src/zest_dac_pkg.sv
src/zest_wb_decode.sv
src/zest_sfr.sv
src/zest_awg.sv
src/zest_dac_mux.sv
src/zest_dac.sv
test/zest_dac_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the zest_dac testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module zest_dac_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vzest_dac_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
